/* verilog.f */
+incdir+include
src/lc3b_types.sv
src/forwarding_selector.sv
src/forwarding_unit.sv
src/lc3b_regfile.sv
src/lc3b_execute.sv
src/lc3b_mem_stage.sv
src/lc3b_backend.sv
sim/tb_lc3b_backend.sv

/* Makefile */
TOP = tb_lc3b_backend

.PHONY: compile run clean

compile:
	verilator --binary --timing --timescale 1ns/1ps -f verilog.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

/* sim/tb_lc3b_backend.sv */
`default_nettype none

module tb_lc3b_backend;
	timeunit 1ns;
	timeprecision 1ps;

	logic                    clk = 1'b0;
	logic                    rst_n;
	logic                    issue_valid;
	lc3b_types::lc3b_ipacket issue_pkt;
	logic                    issue_ready;
	lc3b_types::lc3b_wb_req  wb_req;
	logic                    wb_ack;
	lc3b_types::lc3b_word    wb_dat_in;
	lc3b_types::lc3b_retire  retire;

	// reference model state.
	lc3b_types::lc3b_word   ref_regs [8];
	lc3b_types::lc3b_word   ref_mem [64];
	lc3b_types::lc3b_word   bus_mem [64];
	lc3b_types::lc3b_retire exp_retire [$];
	lc3b_types::lc3b_wb_req exp_bus [$];
	lc3b_types::lc3b_word   pc_count;
	int                     issued = 0;
	int                     pass_count = 0;
	int                     fail_count = 0;

	lc3b_backend lc3b_backend_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.issue_valid (issue_valid),
		.issue_pkt   (issue_pkt),
		.issue_ready (issue_ready),
		.wb_req      (wb_req),
		.wb_ack      (wb_ack),
		.wb_dat_in   (wb_dat_in),
		.retire      (retire)
	);

	always #20 clk = ~clk;

	task automatic report_error(input string msg);
		$display("error: %s", msg);
		fail_count++;
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic check_retire(
		input lc3b_types::lc3b_retire got,
		input lc3b_types::lc3b_retire exp
	);
		if (got !== exp) begin
			$display("mismatch retire: got %h expected %h", got, exp);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic check_wb_req(
		input lc3b_types::lc3b_wb_req got,
		input lc3b_types::lc3b_wb_req exp
	);
		lc3b_types::lc3b_wb_req want;
		want = exp;
		// write data means nothing on a read.
		if (!want.we) begin
			want.dat = got.dat;
		end
		if (got !== want) begin
			$display("mismatch wb_req: got %h expected %h", got, want);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	// fill depends on the whole word address.
	function automatic lc3b_types::lc3b_word fill_word(input int i);
		return 16'h3c00 ^ lc3b_types::lc3b_word'(i * 257);
	endfunction

	function automatic lc3b_types::lc3b_reg rand_reg();
		logic [31:0] r;
		r = $urandom;
		return r[2:0];
	endfunction

	function automatic lc3b_types::lc3b_word rand_word();
		logic [31:0] r;
		r = $urandom;
		return r[15:0];
	endfunction

	function automatic lc3b_types::lc3b_word rand_imm5();
		logic [31:0] r;
		r = $urandom;
		return {{11{r[4]}}, r[4:0]};
	endfunction

	// decode hands over byte offsets.
	function automatic lc3b_types::lc3b_word rand_off6();
		logic [31:0] r;
		r = $urandom;
		return {{9{r[5]}}, r[5:0], 1'b0};
	endfunction

	function automatic lc3b_types::lc3b_ipacket make_pkt(
		input lc3b_types::lc3b_opcode op,
		input lc3b_types::lc3b_reg    dr,
		input lc3b_types::lc3b_reg    sr1,
		input lc3b_types::lc3b_reg    sr2,
		input lc3b_types::lc3b_word   imm,
		input logic                   imm_mode
	);
		lc3b_types::lc3b_ipacket p;
		p = '0;
		p.valid = 1'b1;
		p.opcode = op;
		p.dr = dr;
		p.sr1 = sr1;
		p.sr2 = sr2;
		p.imm = imm;
		p.imm_mode = imm_mode;
		p.regwrite = (op != lc3b_types::op_str);
		return p;
	endfunction

	// in-order model, applied when the packet is accepted.
	task automatic apply_reference(input lc3b_types::lc3b_ipacket p);
		lc3b_types::lc3b_word   a;
		lc3b_types::lc3b_word   b;
		lc3b_types::lc3b_word   addr;
		lc3b_types::lc3b_word   res;
		lc3b_types::lc3b_wb_req req;
		lc3b_types::lc3b_retire ret;
		a = ref_regs[p.sr1];
		b = p.imm_mode ? p.imm : ref_regs[p.sr2];
		addr = a + p.imm;
		res = '0;
		case (p.opcode)
			lc3b_types::op_add: res = a + b;
			lc3b_types::op_and: res = a & b;
			lc3b_types::op_not: res = ~a;
			lc3b_types::op_lea: res = p.pc + p.imm;
			lc3b_types::op_jsr: res = p.pc;
			lc3b_types::op_ldr: res = ref_mem[addr[6:1]];
			lc3b_types::op_str: ref_mem[addr[6:1]] = ref_regs[p.sr2];
			default: res = '0;
		endcase
		if (p.opcode == lc3b_types::op_ldr || p.opcode == lc3b_types::op_str) begin
			req.cyc = 1'b1;
			req.stb = 1'b1;
			req.we = (p.opcode == lc3b_types::op_str);
			req.adr = addr[15:1];
			req.dat = ref_regs[p.sr2];
			req.sel = 2'b11;
			exp_bus.push_back(req);
		end
		if (p.regwrite) begin
			ref_regs[p.dr] = res;
			ret.valid = 1'b1;
			ret.dr = p.dr;
			ret.value = res;
			exp_retire.push_back(ret);
		end
	endtask

	// called on a falling edge, returns on the falling edge after acceptance.
	task automatic issue(input lc3b_types::lc3b_ipacket p);
		pc_count = pc_count + 16'd2;
		p.pc = pc_count;
		issue_pkt = p;
		issue_valid = 1'b1;
		#1;
		while (!issue_ready) begin
			@(negedge clk);
			#1;
		end
		@(posedge clk);
		issued++;
		apply_reference(p);
		@(negedge clk);
		issue_valid = 1'b0;
	endtask

	task automatic finish_test(input string name, input int errs_before);
		while (exp_retire.size() != 0 || exp_bus.size() != 0) begin
			@(negedge clk);
		end
		// quiet window to catch a repeated retire.
		repeat (2) @(negedge clk);
		$display("test %s: done, %0d errors", name, fail_count - errs_before);
	endtask

	task automatic test_reset();
		int errs;
		errs = fail_count;
		check_flag("retire.valid", retire.valid, 1'b0);
		check_flag("wb_req.cyc", wb_req.cyc, 1'b0);
		check_flag("wb_req.stb", wb_req.stb, 1'b0);
		check_flag("issue_ready", issue_ready, 1'b1);
		issue(make_pkt(lc3b_types::op_add, 3'd1, 3'd0, 3'd0, 16'd9, 1'b1));
		check_flag("retire.valid", retire.valid, 1'b0);
		@(negedge clk);
		check_flag("retire.valid", retire.valid, 1'b0);
		@(negedge clk);
		check_flag("retire.valid", retire.valid, 1'b1);
		finish_test("reset", errs);
	endtask

	task automatic test_alu_forwarding();
		int errs;
		errs = fail_count;
		issue(make_pkt(lc3b_types::op_add, 3'd1, 3'd0, 3'd0, rand_imm5(), 1'b1));
		issue(make_pkt(lc3b_types::op_add, 3'd2, 3'd1, 3'd0, rand_imm5(), 1'b1));
		issue(make_pkt(lc3b_types::op_and, 3'd3, 3'd1, 3'd2, '0, 1'b0));
		issue(make_pkt(lc3b_types::op_not, 3'd4, 3'd3, 3'd0, '0, 1'b0));
		issue(make_pkt(lc3b_types::op_add, 3'd5, 3'd4, 3'd3, '0, 1'b0));
		issue(make_pkt(lc3b_types::op_and, 3'd6, 3'd5, 3'd0, rand_imm5(), 1'b1));
		issue(make_pkt(lc3b_types::op_not, 3'd1, 3'd6, 3'd0, '0, 1'b0));
		issue(make_pkt(lc3b_types::op_add, 3'd1, 3'd1, 3'd6, '0, 1'b0));
		finish_test("alu_forwarding", errs);
	endtask

	task automatic test_lea_jsr();
		int errs;
		errs = fail_count;
		issue(make_pkt(lc3b_types::op_lea, 3'd2, 3'd0, 3'd0, rand_off6(), 1'b0));
		issue(make_pkt(lc3b_types::op_jsr, 3'd7, 3'd0, 3'd0, '0, 1'b0));
		issue(make_pkt(lc3b_types::op_add, 3'd3, 3'd7, 3'd0, '0, 1'b1));
		issue(make_pkt(lc3b_types::op_add, 3'd4, 3'd7, 3'd2, '0, 1'b0));
		finish_test("lea_jsr", errs);
	endtask

	task automatic test_store_load();
		int                   errs;
		lc3b_types::lc3b_word off;
		errs = fail_count;
		repeat (4) begin
			off = rand_off6();
			issue(make_pkt(lc3b_types::op_add, 3'd1, 3'd0, 3'd0, rand_imm5(), 1'b1));
			issue(make_pkt(lc3b_types::op_lea, 3'd2, 3'd0, 3'd0, rand_word(), 1'b0));
			issue(make_pkt(lc3b_types::op_str, 3'd0, 3'd1, 3'd2, off, 1'b0));
			issue(make_pkt(lc3b_types::op_ldr, 3'd3, 3'd1, 3'd0, off, 1'b0));
			issue(make_pkt(lc3b_types::op_add, 3'd4, 3'd3, 3'd3, '0, 1'b0));
		end
		finish_test("store_load", errs);
	endtask

	task automatic test_random();
		int                      errs;
		int                      sel;
		logic [31:0]             r;
		lc3b_types::lc3b_ipacket p;
		errs = fail_count;
		for (int n = 0; n < 100; n++) begin
			sel = $urandom_range(6, 0);
			r = $urandom;
			case (sel)
				0: p = make_pkt(lc3b_types::op_add, rand_reg(), rand_reg(), rand_reg(),
					rand_imm5(), r[8]);
				1: p = make_pkt(lc3b_types::op_and, rand_reg(), rand_reg(), rand_reg(),
					rand_imm5(), r[8]);
				2: p = make_pkt(lc3b_types::op_not, rand_reg(), rand_reg(), 3'd0, '0, 1'b0);
				3: p = make_pkt(lc3b_types::op_lea, rand_reg(), 3'd0, 3'd0, rand_off6(), 1'b0);
				4: p = make_pkt(lc3b_types::op_jsr, 3'd7, 3'd0, 3'd0, '0, 1'b0);
				5: p = make_pkt(lc3b_types::op_ldr, rand_reg(), rand_reg(), 3'd0,
					rand_off6(), 1'b0);
				default: p = make_pkt(lc3b_types::op_str, 3'd0, rand_reg(), rand_reg(),
					rand_off6(), 1'b0);
			endcase
			issue(p);
			// occasional idle cycle between issues.
			if (r[12:11] == 2'b00) begin
				@(negedge clk);
			end
		end
		finish_test("random", errs);
	endtask

	// wishbone slave, ack after 0 to 3 wait cycles.
	initial begin : bus_slave
		lc3b_types::lc3b_wb_req want;
		int                     ack_wait;
		wb_ack = 1'b0;
		wb_dat_in = '0;
		ack_wait = 0;
		for (int i = 0; i < 64; i++) begin
			bus_mem[i] = fill_word(i);
		end
		forever begin
			@(negedge clk);
			if (wb_ack) begin
				wb_ack = 1'b0;
				ack_wait = $urandom_range(3, 0);
			end else if (wb_req.cyc && wb_req.stb) begin
				if (ack_wait > 0) begin
					ack_wait--;
				end else if (exp_bus.size() == 0) begin
					report_error("wishbone cycle with no load or store in flight");
					wb_ack = 1'b1;
				end else begin
					want = exp_bus.pop_front();
					check_wb_req(wb_req, want);
					if (wb_req.we) begin
						bus_mem[wb_req.adr[5:0]] = wb_req.dat;
					end
					wb_dat_in = bus_mem[wb_req.adr[5:0]];
					wb_ack = 1'b1;
				end
			end
		end
	end

	initial begin : retire_monitor
		lc3b_types::lc3b_retire want;
		forever begin
			@(negedge clk);
			if (retire.valid === 1'b1) begin
				if (exp_retire.size() == 0) begin
					report_error($sformatf("retire of r%0d with nothing expected", retire.dr));
				end else begin
					want = exp_retire.pop_front();
					check_retire(retire, want);
				end
			end
		end
	end

	// issue_ready drops only for an open, unacknowledged bus cycle.
	initial begin : ready_monitor
		forever begin
			@(negedge clk);
			#1;
			if (rst_n === 1'b1) begin
				check_flag("issue_ready", issue_ready, !(wb_req.cyc && !wb_ack));
			end
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < issued * 8 + 200) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", cycles);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'h55f0));
		rst_n = 1'b0;
		issue_valid = 1'b0;
		issue_pkt = '0;
		pc_count = 16'h3000;
		for (int i = 0; i < 8; i++) begin
			ref_regs[i] = '0;
		end
		for (int i = 0; i < 64; i++) begin
			ref_mem[i] = fill_word(i);
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		test_reset();
		test_alu_forwarding();
		test_lea_jsr();
		test_store_load();
		test_random();
		$display("checks: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* src/lc3b_backend.sv */
`default_nettype none

module lc3b_backend (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    issue_valid,
	input  lc3b_types::lc3b_ipacket issue_pkt,
	output logic                    issue_ready,
	output lc3b_types::lc3b_wb_req  wb_req,
	input  logic                    wb_ack,
	input  lc3b_types::lc3b_word    wb_dat_in,
	output lc3b_types::lc3b_retire  retire
);

	lc3b_types::lc3b_ipacket ex_packet;
	lc3b_types::lc3b_ipacket mem_packet;
	lc3b_types::lc3b_ipacket wb_packet;
	lc3b_types::lc3b_word    rf_sr1_data;
	lc3b_types::lc3b_word    rf_sr2_data;
	lc3b_types::lc3b_word    sr1_value;
	lc3b_types::lc3b_word    sr2_value;
	lc3b_types::lc3b_word    mem_alu_data;
	lc3b_types::lc3b_word    mem_addrgen;
	lc3b_types::lc3b_word    mem_store_data;
	lc3b_types::lc3b_word    mem_out;
	lc3b_types::lc3b_word    wb_data;
	lc3b_types::lc3b_word    wb_out;
	logic                    stall;

	assign issue_ready = !stall;

	assign retire = '{
		valid: wb_packet.valid && wb_packet.regwrite,
		dr:    wb_packet.dr,
		value: wb_out
	};

	lc3b_regfile lc3b_regfile_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.sr1      (ex_packet.sr1),
		.sr2      (ex_packet.sr2),
		.sr1_data (rf_sr1_data),
		.sr2_data (rf_sr2_data),
		.retire   (retire)
	);

	forwarding_unit forwarding_unit_i (
		.ex_packet   (ex_packet),
		.mem_packet  (mem_packet),
		.wb_packet   (wb_packet),
		.rf_sr1_data (rf_sr1_data),
		.rf_sr2_data (rf_sr2_data),
		.mem_out     (mem_out),
		.wb_out      (wb_out),
		.sr1_value   (sr1_value),
		.sr2_value   (sr2_value)
	);

	lc3b_execute lc3b_execute_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.stall          (stall),
		.issue_valid    (issue_valid),
		.issue_pkt      (issue_pkt),
		.sr1_value      (sr1_value),
		.sr2_value      (sr2_value),
		.ex_packet      (ex_packet),
		.mem_packet     (mem_packet),
		.mem_alu_data   (mem_alu_data),
		.mem_addrgen    (mem_addrgen),
		.mem_store_data (mem_store_data)
	);

	forwarding_selector forwarding_selector_i (
		.mem_rdata    (wb_dat_in),
		.mem_alu_data (mem_alu_data),
		.mem_addrgen  (mem_addrgen),
		.wb_data      (wb_data),
		.mem_packet   (mem_packet),
		.wb_packet    (wb_packet),
		.mem_out      (mem_out),
		.wb_out       (wb_out)
	);

	lc3b_mem_stage lc3b_mem_stage_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.mem_packet     (mem_packet),
		.mem_addrgen    (mem_addrgen),
		.mem_store_data (mem_store_data),
		.mem_out        (mem_out),
		.wb_req         (wb_req),
		.wb_ack         (wb_ack),
		.stall          (stall),
		.wb_packet      (wb_packet),
		.wb_data        (wb_data)
	);

endmodule

`default_nettype wire

/* src/lc3b_mem_stage.sv */
`default_nettype none

`include "lc3b_config.svh"

module lc3b_mem_stage (
	input  logic                    clk,
	input  logic                    rst_n,
	input  lc3b_types::lc3b_ipacket mem_packet,
	input  lc3b_types::lc3b_word    mem_addrgen,
	input  lc3b_types::lc3b_word    mem_store_data,
	input  lc3b_types::lc3b_word    mem_out,
	output lc3b_types::lc3b_wb_req  wb_req,
	input  logic                    wb_ack,
	output logic                    stall,
	output lc3b_types::lc3b_ipacket wb_packet,
	output lc3b_types::lc3b_word    wb_data
);

	typedef enum logic {s_idle, s_bus} state_t;

	state_t                     state;
	logic                       pending;
	logic                       is_store;
	logic                       we_hold;
	logic [`LC3B_WORD_BITS-2:0] adr_hold;
	lc3b_types::lc3b_word       dat_hold;

	assign is_store = (mem_packet.opcode == lc3b_types::op_str);
	assign pending  = mem_packet.valid &&
		((mem_packet.opcode == lc3b_types::op_ldr) || is_store);

	// cycle opens combinationally, then runs from the held copy.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= s_idle;
		end else if (state == s_idle) begin
			if (pending && !wb_ack) begin
				state <= s_bus;
			end
		end else if (wb_ack) begin
			state <= s_idle;
		end
	end

	always_ff @(posedge clk) begin
		if (state == s_idle) begin
			we_hold  <= is_store;
			adr_hold <= mem_addrgen[`LC3B_WORD_BITS-1:1];
			dat_hold <= mem_store_data;
		end
	end

	always_comb begin
		wb_req.cyc = (state == s_bus) || pending;
		wb_req.stb = wb_req.cyc;
		wb_req.we  = (state == s_bus) ? we_hold : is_store;
		wb_req.adr = (state == s_bus) ? adr_hold : mem_addrgen[`LC3B_WORD_BITS-1:1];
		wb_req.dat = (state == s_bus) ? dat_hold : mem_store_data;
		wb_req.sel = 2'b11;
	end

	assign stall = wb_req.cyc && !wb_ack;

	// bubble on stall so no write repeats.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_packet <= '0;
		end else if (stall) begin
			wb_packet.valid <= 1'b0;
		end else begin
			wb_packet <= mem_packet;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			wb_data <= mem_out;
		end
	end

endmodule

`default_nettype wire

/* src/lc3b_execute.sv */
`default_nettype none

module lc3b_execute (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    stall,
	input  logic                    issue_valid,
	input  lc3b_types::lc3b_ipacket issue_pkt,
	input  lc3b_types::lc3b_word    sr1_value,
	input  lc3b_types::lc3b_word    sr2_value,
	output lc3b_types::lc3b_ipacket ex_packet,
	output lc3b_types::lc3b_ipacket mem_packet,
	output lc3b_types::lc3b_word    mem_alu_data,
	output lc3b_types::lc3b_word    mem_addrgen,
	output lc3b_types::lc3b_word    mem_store_data
);

	lc3b_types::lc3b_word operand_b;
	lc3b_types::lc3b_word alu_result;
	lc3b_types::lc3b_word addr_base;
	lc3b_types::lc3b_word addr_result;

	// execute register.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_packet <= '0;
		end else if (!stall) begin
			ex_packet       <= issue_pkt;
			ex_packet.valid <= issue_valid;
		end
	end

	assign operand_b = ex_packet.imm_mode ? ex_packet.imm : sr2_value;

	always_comb begin
		case (ex_packet.opcode)
			lc3b_types::op_add: alu_result = sr1_value + operand_b;
			lc3b_types::op_and: alu_result = sr1_value & operand_b;
			lc3b_types::op_not: alu_result = ~sr1_value;
			default:            alu_result = sr1_value;
		endcase
	end

	// lea is pc relative, ldr and str are base plus offset.
	assign addr_base   = (ex_packet.opcode == lc3b_types::op_lea) ? ex_packet.pc : sr1_value;
	assign addr_result = addr_base + ex_packet.imm;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_packet <= '0;
		end else if (!stall) begin
			mem_packet <= ex_packet;
		end
	end

	// payload of the memory-stage register.
	// store source travels in the sr2 field.
	always_ff @(posedge clk) begin
		if (!stall) begin
			mem_alu_data   <= alu_result;
			mem_addrgen    <= addr_result;
			mem_store_data <= sr2_value;
		end
	end

endmodule

`default_nettype wire

/* src/lc3b_regfile.sv */
`default_nettype none

`include "lc3b_config.svh"

module lc3b_regfile (
	input  logic                   clk,
	input  logic                   rst_n,
	input  lc3b_types::lc3b_reg    sr1,
	input  lc3b_types::lc3b_reg    sr2,
	output lc3b_types::lc3b_word   sr1_data,
	output lc3b_types::lc3b_word   sr2_data,
	input  lc3b_types::lc3b_retire retire
);

	lc3b_types::lc3b_word regs [`LC3B_REG_COUNT];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `LC3B_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (retire.valid) begin
			regs[retire.dr] <= retire.value;
		end
	end

	// no bypass, writeback forwarding covers it.
	assign sr1_data = regs[sr1];
	assign sr2_data = regs[sr2];

endmodule

`default_nettype wire

/* src/forwarding_unit.sv */
`default_nettype none

module forwarding_unit (
	input  lc3b_types::lc3b_ipacket ex_packet,
	input  lc3b_types::lc3b_ipacket mem_packet,
	input  lc3b_types::lc3b_ipacket wb_packet,
	input  lc3b_types::lc3b_word    rf_sr1_data,
	input  lc3b_types::lc3b_word    rf_sr2_data,
	input  lc3b_types::lc3b_word    mem_out,
	input  lc3b_types::lc3b_word    wb_out,
	output lc3b_types::lc3b_word    sr1_value,
	output lc3b_types::lc3b_word    sr2_value
);

	logic mem_writes;
	logic wb_writes;

	assign mem_writes = mem_packet.valid && mem_packet.regwrite;
	assign wb_writes  = wb_packet.valid && wb_packet.regwrite;

	// memory stage is younger, so it wins.
	always_comb begin
		if (mem_writes && (mem_packet.dr == ex_packet.sr1)) begin
			sr1_value = mem_out;
		end else if (wb_writes && (wb_packet.dr == ex_packet.sr1)) begin
			sr1_value = wb_out;
		end else begin
			sr1_value = rf_sr1_data;
		end
	end

	always_comb begin
		if (mem_writes && (mem_packet.dr == ex_packet.sr2)) begin
			sr2_value = mem_out;
		end else if (wb_writes && (wb_packet.dr == ex_packet.sr2)) begin
			sr2_value = wb_out;
		end else begin
			sr2_value = rf_sr2_data;
		end
	end

endmodule

`default_nettype wire

/* src/forwarding_selector.sv */
`default_nettype none

`include "lc3b_config.svh"

module forwarding_selector (
	input  lc3b_types::lc3b_word    mem_rdata,
	input  lc3b_types::lc3b_word    mem_alu_data,
	input  lc3b_types::lc3b_word    mem_addrgen,
	input  lc3b_types::lc3b_word    wb_data,
	input  lc3b_types::lc3b_ipacket mem_packet,
	input  lc3b_types::lc3b_ipacket wb_packet,
	output lc3b_types::lc3b_word    mem_out,
	output lc3b_types::lc3b_word    wb_out
);

	// value the memory-stage instruction will write.
	always_comb begin
		case (mem_packet.opcode)
			lc3b_types::op_add,
			lc3b_types::op_and,
			lc3b_types::op_not,
			lc3b_types::op_x,
			lc3b_types::op_shf: begin
				mem_out = mem_alu_data;
			end
			lc3b_types::op_ldb,
			lc3b_types::op_ldi,
			lc3b_types::op_ldr,
			lc3b_types::op_stb,
			lc3b_types::op_sti,
			lc3b_types::op_str: begin
				mem_out = mem_rdata;
			end
			lc3b_types::op_lea: begin
				mem_out = mem_addrgen;
			end
			lc3b_types::op_jsr,
			lc3b_types::op_trap: begin
				mem_out = mem_packet.pc;
			end
			default: begin
				// br and jmp land here.
				mem_out = `LC3B_DEBUG_FILL;
			end
		endcase
	end

	// writeback data was already chosen one stage earlier.
	always_comb begin
		case (wb_packet.opcode)
			lc3b_types::op_jsr,
			lc3b_types::op_trap: begin
				wb_out = wb_packet.pc;
			end
			default: begin
				wb_out = wb_data;
			end
		endcase
	end

endmodule

`default_nettype wire

/* src/lc3b_types.sv */
`default_nettype none

`include "lc3b_config.svh"

package lc3b_types;

	typedef logic [`LC3B_WORD_BITS-1:0] lc3b_word;
	typedef logic [$clog2(`LC3B_REG_COUNT)-1:0] lc3b_reg;

	// lc-3b opcode field, bits 15:12.
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_x    = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	// decoded instruction, pc is already incremented.
	typedef struct packed {
		logic       valid;
		lc3b_opcode opcode;
		lc3b_word   pc;
		lc3b_reg    dr;
		lc3b_reg    sr1;
		lc3b_reg    sr2;
		lc3b_word   imm;
		logic       imm_mode;
		logic       regwrite;
	} lc3b_ipacket;

	// wishbone classic master outputs.
	typedef struct packed {
		logic                       cyc;
		logic                       stb;
		logic                       we;
		logic [`LC3B_WORD_BITS-2:0] adr;
		lc3b_word                   dat;
		logic [1:0]                 sel;
	} lc3b_wb_req;

	typedef struct packed {
		logic     valid;
		lc3b_reg  dr;
		lc3b_word value;
	} lc3b_retire;

endpackage

`default_nettype wire

/* include/lc3b_config.svh */
`ifndef LC3B_CONFIG_SVH
`define LC3B_CONFIG_SVH

// data and address width.
`define LC3B_WORD_BITS 16

// architectural registers.
`define LC3B_REG_COUNT 8

// result of opcodes that write nothing, easy to spot on a waveform.
`define LC3B_DEBUG_FILL 16'hbbbb

`endif
